//--- src/loopback_pkg.sv
`default_nettype none

package loopback_pkg;

    // Field types of the parsed UDP header and its payload
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_length_t;
    typedef logic [31:0] ipv4_addr_t;

    // Frames sent to this port come back to the sender
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Payload buffer size is a power of two so the pointers wrap by themselves
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // Decision taken at header time, applied to the payload that follows
    typedef enum logic [1:0] {
        FILT_IDLE,
        FILT_FORWARD,
        FILT_DISCARD
    } filter_state_t;

endpackage

`default_nettype wire

//--- src/udp_port_filter.sv
`timescale 1ns/100ps
`default_nettype none

module udp_port_filter import loopback_pkg::*; (
    input  logic        clk_125mhz,
    input  logic        rst_125mhz,

    input  logic        rx_udp_hdr_valid,
    output logic        rx_udp_hdr_ready,
    input  ipv4_addr_t  rx_udp_ip_source_ip,
    input  udp_port_t   rx_udp_source_port,
    input  udp_port_t   rx_udp_dest_port,
    input  udp_length_t rx_udp_length,

    output logic        tx_udp_hdr_valid,
    input  logic        tx_udp_hdr_ready,
    output ipv4_addr_t  tx_udp_ip_dest_ip,
    output udp_port_t   tx_udp_source_port,
    output udp_port_t   tx_udp_dest_port,
    output udp_length_t tx_udp_length,

    input  byte_t       rx_udp_payload_tdata,
    input  logic        rx_udp_payload_tvalid,
    output logic        rx_udp_payload_tready,
    input  logic        rx_udp_payload_tlast,
    input  logic        rx_udp_payload_tuser,

    output byte_t       fifo_in_tdata,
    output logic        fifo_in_tvalid,
    input  logic        fifo_in_tready,
    output logic        fifo_in_tlast,
    output logic        fifo_in_tuser
);

    filter_state_t state;
    logic          match;
    logic          hdr_xfer;
    logic          last_xfer;

    assign match = (rx_udp_dest_port == ECHO_PORT);

    // Header is only looked at between frames
    always_comb begin
        rx_udp_hdr_ready = 1'b0;
        tx_udp_hdr_valid = 1'b0;
        if (state == FILT_IDLE) begin
            // A reply needs the downstream header slot, a drop does not
            rx_udp_hdr_ready = match ? tx_udp_hdr_ready : 1'b1;
            tx_udp_hdr_valid = rx_udp_hdr_valid && match;
        end
    end

    // Reply goes back where it came from
    assign tx_udp_ip_dest_ip  = rx_udp_ip_source_ip;
    assign tx_udp_source_port = rx_udp_dest_port;
    assign tx_udp_dest_port   = rx_udp_source_port;
    assign tx_udp_length      = rx_udp_length;

    always_comb begin
        unique case (state)
            FILT_FORWARD: rx_udp_payload_tready = fifo_in_tready;
            FILT_DISCARD: rx_udp_payload_tready = 1'b1;
            default:      rx_udp_payload_tready = 1'b0;
        endcase
    end

    assign fifo_in_tdata  = rx_udp_payload_tdata;
    assign fifo_in_tvalid = rx_udp_payload_tvalid && (state == FILT_FORWARD);
    assign fifo_in_tlast  = rx_udp_payload_tlast;
    assign fifo_in_tuser  = rx_udp_payload_tuser;

    assign hdr_xfer  = rx_udp_hdr_valid && rx_udp_hdr_ready;
    assign last_xfer = rx_udp_payload_tvalid && rx_udp_payload_tready && rx_udp_payload_tlast;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= FILT_IDLE;
        end else begin
            unique case (state)
                FILT_IDLE: begin
                    if (hdr_xfer) begin
                        state <= match ? FILT_FORWARD : FILT_DISCARD;
                    end
                end
                FILT_FORWARD, FILT_DISCARD: begin
                    if (last_xfer) begin
                        state <= FILT_IDLE;
                    end
                end
                default: state <= FILT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/payload_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module payload_fifo import loopback_pkg::*; (
    input  logic  clk_125mhz,
    input  logic  rst_125mhz,

    input  byte_t in_tdata,
    input  logic  in_tvalid,
    output logic  in_tready,
    input  logic  in_tlast,
    input  logic  in_tuser,

    output byte_t out_tdata,
    output logic  out_tvalid,
    input  logic  out_tready,
    output logic  out_tlast,
    output logic  out_tuser
);

    // One storage slot per payload byte with its flags alongside
    byte_t mem_data [FIFO_DEPTH];
    logic  mem_last [FIFO_DEPTH];
    logic  mem_user [FIFO_DEPTH];

    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    // One bit wider than the pointers to tell full from empty
    logic [FIFO_ADDR_W:0]   count;

    logic wr_en;
    logic rd_en;

    assign in_tready  = (count != (FIFO_ADDR_W + 1)'(FIFO_DEPTH));
    assign out_tvalid = (count != '0);

    assign wr_en = in_tvalid && in_tready;
    assign rd_en = out_tvalid && out_tready;

    // Head entry is shown directly and held until it is taken
    assign out_tdata = mem_data[rd_ptr];
    assign out_tlast = mem_last[rd_ptr];
    assign out_tuser = mem_user[rd_ptr];

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= in_tdata;
            mem_last[wr_ptr] <= in_tlast;
            mem_user[wr_ptr] <= in_tuser;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the level alone
            unique case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/first_byte_led.sv
`timescale 1ns/100ps
`default_nettype none

module first_byte_led import loopback_pkg::*; (
    input  logic  clk_125mhz,
    input  logic  rst_125mhz,

    input  byte_t tdata,
    input  logic  tvalid,
    input  logic  tready,
    input  logic  tlast,

    output logic  led
);

    // High from the first byte of a frame until its last byte leaves
    logic in_frame;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            in_frame <= 1'b0;
            led      <= 1'b0;
        end else begin
            if (tvalid && !in_frame) begin
                led      <= tdata[0];
                in_frame <= 1'b1;
            end
            // A stalled last beat keeps the frame open, so it is not taken as a new first byte
            if (tvalid && tready && tlast) begin
                in_frame <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/udp_loopback_top.sv
`timescale 1ns/100ps
`default_nettype none

module udp_loopback_top import loopback_pkg::*; (
    input  logic        clk_125mhz,
    input  logic        rst_125mhz,

    // Parsed frames from the UDP stack
    input  logic        rx_udp_hdr_valid,
    output logic        rx_udp_hdr_ready,
    input  ipv4_addr_t  rx_udp_ip_source_ip,
    input  udp_port_t   rx_udp_source_port,
    input  udp_port_t   rx_udp_dest_port,
    input  udp_length_t rx_udp_length,
    input  byte_t       rx_udp_payload_tdata,
    input  logic        rx_udp_payload_tvalid,
    output logic        rx_udp_payload_tready,
    input  logic        rx_udp_payload_tlast,
    input  logic        rx_udp_payload_tuser,

    // Echo replies back to the stack
    output logic        tx_udp_hdr_valid,
    input  logic        tx_udp_hdr_ready,
    output ipv4_addr_t  tx_udp_ip_dest_ip,
    output udp_port_t   tx_udp_source_port,
    output udp_port_t   tx_udp_dest_port,
    output udp_length_t tx_udp_length,
    output byte_t       tx_udp_payload_tdata,
    output logic        tx_udp_payload_tvalid,
    input  logic        tx_udp_payload_tready,
    output logic        tx_udp_payload_tlast,
    output logic        tx_udp_payload_tuser,

    output logic        led
);

    byte_t fifo_in_tdata;
    logic  fifo_in_tvalid;
    logic  fifo_in_tready;
    logic  fifo_in_tlast;
    logic  fifo_in_tuser;

    udp_port_filter i_filter (
        .clk_125mhz            (clk_125mhz),
        .rst_125mhz            (rst_125mhz),
        .rx_udp_hdr_valid      (rx_udp_hdr_valid),
        .rx_udp_hdr_ready      (rx_udp_hdr_ready),
        .rx_udp_ip_source_ip   (rx_udp_ip_source_ip),
        .rx_udp_source_port    (rx_udp_source_port),
        .rx_udp_dest_port      (rx_udp_dest_port),
        .rx_udp_length         (rx_udp_length),
        .tx_udp_hdr_valid      (tx_udp_hdr_valid),
        .tx_udp_hdr_ready      (tx_udp_hdr_ready),
        .tx_udp_ip_dest_ip     (tx_udp_ip_dest_ip),
        .tx_udp_source_port    (tx_udp_source_port),
        .tx_udp_dest_port      (tx_udp_dest_port),
        .tx_udp_length         (tx_udp_length),
        .rx_udp_payload_tdata  (rx_udp_payload_tdata),
        .rx_udp_payload_tvalid (rx_udp_payload_tvalid),
        .rx_udp_payload_tready (rx_udp_payload_tready),
        .rx_udp_payload_tlast  (rx_udp_payload_tlast),
        .rx_udp_payload_tuser  (rx_udp_payload_tuser),
        .fifo_in_tdata         (fifo_in_tdata),
        .fifo_in_tvalid        (fifo_in_tvalid),
        .fifo_in_tready        (fifo_in_tready),
        .fifo_in_tlast         (fifo_in_tlast),
        .fifo_in_tuser         (fifo_in_tuser)
    );

    payload_fifo i_fifo (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .in_tdata   (fifo_in_tdata),
        .in_tvalid  (fifo_in_tvalid),
        .in_tready  (fifo_in_tready),
        .in_tlast   (fifo_in_tlast),
        .in_tuser   (fifo_in_tuser),
        .out_tdata  (tx_udp_payload_tdata),
        .out_tvalid (tx_udp_payload_tvalid),
        .out_tready (tx_udp_payload_tready),
        .out_tlast  (tx_udp_payload_tlast),
        .out_tuser  (tx_udp_payload_tuser)
    );

    // Watches the reply payload as it leaves
    first_byte_led i_led (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .tdata      (tx_udp_payload_tdata),
        .tvalid     (tx_udp_payload_tvalid),
        .tready     (tx_udp_payload_tready),
        .tlast      (tx_udp_payload_tlast),
        .led        (led)
    );

endmodule

`default_nettype wire

//--- dv/tb_udp_loopback.sv
`timescale 1ns/100ps
`default_nettype none

module tb_udp_loopback import loopback_pkg::*; ();

    localparam int NUM_FRAMES   = 8;
    localparam int RESET_CYCLES = 16;

    logic        clk_125mhz;
    logic        rst_125mhz;
    logic        rx_udp_hdr_valid;
    logic        rx_udp_hdr_ready;
    ipv4_addr_t  rx_udp_ip_source_ip;
    udp_port_t   rx_udp_source_port;
    udp_port_t   rx_udp_dest_port;
    udp_length_t rx_udp_length;
    byte_t       rx_udp_payload_tdata;
    logic        rx_udp_payload_tvalid;
    logic        rx_udp_payload_tready;
    logic        rx_udp_payload_tlast;
    logic        rx_udp_payload_tuser;
    logic        tx_udp_hdr_valid;
    logic        tx_udp_hdr_ready;
    ipv4_addr_t  tx_udp_ip_dest_ip;
    udp_port_t   tx_udp_source_port;
    udp_port_t   tx_udp_dest_port;
    udp_length_t tx_udp_length;
    byte_t       tx_udp_payload_tdata;
    logic        tx_udp_payload_tvalid;
    logic        tx_udp_payload_tready;
    logic        tx_udp_payload_tlast;
    logic        tx_udp_payload_tuser;
    logic        led;

    // Frame table with one array per column
    udp_port_t  dest_tbl  [NUM_FRAMES] = '{16'd80, ECHO_PORT, ECHO_PORT, 16'd53,
                                           ECHO_PORT, 16'd1235, ECHO_PORT, ECHO_PORT};
    udp_port_t  src_tbl   [NUM_FRAMES] = '{16'd5000, 16'd5001, 16'd40000, 16'd53,
                                           16'd7, 16'd65535, 16'd1234, 16'd32768};
    ipv4_addr_t ip_tbl    [NUM_FRAMES] = '{32'hc0a8_0164, 32'hc0a8_0102, 32'h0a00_0001,
                                           32'h0808_0808, 32'hac10_fe01, 32'hffff_ffff,
                                           32'h7f00_0001, 32'hc0a8_01fe};
    int         len_tbl   [NUM_FRAMES] = '{3, 5, 40, 1, 20, 8, 33, 12};
    byte_t      first_tbl [NUM_FRAMES] = '{8'h11, 8'h41, 8'hc0, 8'h01,
                                           8'h17, 8'h22, 8'hf2, 8'h5b};
    logic       user_tbl  [NUM_FRAMES] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};

    // Expected reply bytes, oldest first
    byte_t exp_data [$];
    logic  exp_last [$];
    logic  exp_user [$];

    logic   led_exp;
    integer seed = 32'hd719_1aba;

    udp_loopback_top i_dut (
        .clk_125mhz            (clk_125mhz),
        .rst_125mhz            (rst_125mhz),
        .rx_udp_hdr_valid      (rx_udp_hdr_valid),
        .rx_udp_hdr_ready      (rx_udp_hdr_ready),
        .rx_udp_ip_source_ip   (rx_udp_ip_source_ip),
        .rx_udp_source_port    (rx_udp_source_port),
        .rx_udp_dest_port      (rx_udp_dest_port),
        .rx_udp_length         (rx_udp_length),
        .rx_udp_payload_tdata  (rx_udp_payload_tdata),
        .rx_udp_payload_tvalid (rx_udp_payload_tvalid),
        .rx_udp_payload_tready (rx_udp_payload_tready),
        .rx_udp_payload_tlast  (rx_udp_payload_tlast),
        .rx_udp_payload_tuser  (rx_udp_payload_tuser),
        .tx_udp_hdr_valid      (tx_udp_hdr_valid),
        .tx_udp_hdr_ready      (tx_udp_hdr_ready),
        .tx_udp_ip_dest_ip     (tx_udp_ip_dest_ip),
        .tx_udp_source_port    (tx_udp_source_port),
        .tx_udp_dest_port      (tx_udp_dest_port),
        .tx_udp_length         (tx_udp_length),
        .tx_udp_payload_tdata  (tx_udp_payload_tdata),
        .tx_udp_payload_tvalid (tx_udp_payload_tvalid),
        .tx_udp_payload_tready (tx_udp_payload_tready),
        .tx_udp_payload_tlast  (tx_udp_payload_tlast),
        .tx_udp_payload_tuser  (tx_udp_payload_tuser),
        .led                   (led)
    );

    always #4 clk_125mhz = ~clk_125mhz;

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_port(input string name, input udp_port_t act, input udp_port_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_ip(input string name, input ipv4_addr_t act, input ipv4_addr_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_length(input string name, input udp_length_t act,
                                input udp_length_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_byte(input string name, input byte_t act, input byte_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, act, exp);
            stop_with_failure();
        end
    endtask

    // Reference model for one row
    task automatic queue_reply(input int r);
        for (int i = 0; i < len_tbl[r]; i++) begin
            exp_data.push_back(byte_t'(first_tbl[r] + i));
            exp_last.push_back(i == len_tbl[r] - 1);
            exp_user.push_back((i == len_tbl[r] - 1) ? user_tbl[r] : 1'b0);
        end
        led_exp = first_tbl[r][0];
    endtask

    task automatic send_header(input int r, input logic match);
        rx_udp_hdr_valid    = 1'b1;
        rx_udp_ip_source_ip = ip_tbl[r];
        rx_udp_source_port  = src_tbl[r];
        rx_udp_dest_port    = dest_tbl[r];
        rx_udp_length       = udp_length_t'(len_tbl[r] + 8);
        do begin
            @(negedge clk_125mhz);
            check_bit("tx_udp_hdr_valid", tx_udp_hdr_valid, match);
            check_bit("rx_udp_hdr_ready", rx_udp_hdr_ready, match ? tx_udp_hdr_ready : 1'b1);
            if (match) begin
                check_port("tx_udp_source_port", tx_udp_source_port, dest_tbl[r]);
                check_port("tx_udp_dest_port", tx_udp_dest_port, src_tbl[r]);
                check_ip("tx_udp_ip_dest_ip", tx_udp_ip_dest_ip, ip_tbl[r]);
                check_length("tx_udp_length", tx_udp_length, udp_length_t'(len_tbl[r] + 8));
            end
        end while (!rx_udp_hdr_ready);
        @(posedge clk_125mhz);
        #1;
        rx_udp_hdr_valid = 1'b0;
    endtask

    task automatic send_payload(input int r);
        for (int i = 0; i < len_tbl[r]; i++) begin
            rx_udp_payload_tdata  = byte_t'(first_tbl[r] + i);
            rx_udp_payload_tlast  = (i == len_tbl[r] - 1);
            rx_udp_payload_tuser  = (i == len_tbl[r] - 1) ? user_tbl[r] : 1'b0;
            rx_udp_payload_tvalid = 1'b1;
            do begin
                @(negedge clk_125mhz);
            end while (!rx_udp_payload_tready);
            @(posedge clk_125mhz);
            #1;
        end
        rx_udp_payload_tvalid = 1'b0;
        rx_udp_payload_tlast  = 1'b0;
        rx_udp_payload_tuser  = 1'b0;
    endtask

    // Payload ready stalls half the time to fill the FIFO
    always @(posedge clk_125mhz) begin
        #1;
        tx_udp_payload_tready = ($random(seed) & 1) != 0;
        tx_udp_hdr_ready      = ($random(seed) & 3) != 0;
    end

    // A transfer seen at the falling edge completes on the next rising edge
    always @(negedge clk_125mhz) begin
        if (!rst_125mhz && tx_udp_payload_tvalid && tx_udp_payload_tready) begin
            if (exp_data.size() == 0) begin
                $display("Reply payload byte %h came out with nothing expected at %0t",
                         tx_udp_payload_tdata, $time);
                stop_with_failure();
            end
            check_byte("tx_udp_payload_tdata", tx_udp_payload_tdata, exp_data.pop_front());
            check_bit("tx_udp_payload_tlast", tx_udp_payload_tlast, exp_last.pop_front());
            check_bit("tx_udp_payload_tuser", tx_udp_payload_tuser, exp_user.pop_front());
        end
    end

    initial begin : watchdog
        int limit;
        int cycles;
        limit = 0;
        for (int r = 0; r < NUM_FRAMES; r++) begin
            limit += len_tbl[r] + 1;
        end
        limit  = 4 * limit + RESET_CYCLES;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk_125mhz);
            cycles++;
        end
        $display("Timed out after %0d clock cycles", cycles);
        stop_with_failure();
    end

    initial begin : stimulus
        logic match;
        clk_125mhz            = 1'b0;
        rst_125mhz            = 1'b1;
        rx_udp_hdr_valid      = 1'b0;
        rx_udp_ip_source_ip   = '0;
        rx_udp_source_port    = '0;
        rx_udp_dest_port      = '0;
        rx_udp_length         = '0;
        rx_udp_payload_tdata  = '0;
        rx_udp_payload_tvalid = 1'b0;
        rx_udp_payload_tlast  = 1'b0;
        rx_udp_payload_tuser  = 1'b0;
        tx_udp_hdr_ready      = 1'b0;
        tx_udp_payload_tready = 1'b0;
        led_exp               = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk_125mhz);
        #1;
        rst_125mhz = 1'b0;
        @(negedge clk_125mhz);
        check_bit("led", led, 1'b0);
        check_bit("tx_udp_payload_tvalid", tx_udp_payload_tvalid, 1'b0);
        check_bit("rx_udp_payload_tready", rx_udp_payload_tready, 1'b0);
        @(posedge clk_125mhz);
        #1;

        for (int r = 0; r < NUM_FRAMES; r++) begin
            match = (dest_tbl[r] == ECHO_PORT);
            if (match) begin
                queue_reply(r);
            end
            send_header(r, match);
            send_payload(r);
            // Let the reply drain before the LED is looked at
            while (exp_data.size() != 0) begin
                @(negedge clk_125mhz);
            end
            @(posedge clk_125mhz);
            @(negedge clk_125mhz);
            check_bit("led", led, led_exp);
            @(posedge clk_125mhz);
            #1;
        end

        if (exp_data.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Reply payload bytes still missing at the end of the run");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- sources.f
src/loopback_pkg.sv
src/udp_port_filter.sv
src/payload_fifo.sv
src/first_byte_led.sv
src/udp_loopback_top.sv
dv/tb_udp_loopback.sv
